// ==== verilog/mfe_stream_pkg.sv ====
`default_nettype none

package mfe_stream_pkg;

    // Width of one passphrase character as delivered by the keyboard side
    localparam int CHAR_W = 16;

    // Galois feedback mask applied when a 1 falls out of the keystream LFSR
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    // One word of the file stream, eof marks the last word of a file
    typedef struct packed {
        logic [31:0] data;
        logic        eof;
    } stream_word_t;

    // Field view of the key card word
    // The check value sits in the upper half and the keystream seed below it
    typedef struct packed {
        logic [15:0] check;
        logic [15:0] seed;
    } key_fields_t;

    // The key word is captured raw and read back through its fields
    typedef union packed {
        logic [31:0] raw;
        key_fields_t f;
    } key_word_u;

endpackage

`default_nettype wire

// ==== verilog/mfe_ctrl_pkg.sv ====
`default_nettype none

package mfe_ctrl_pkg;

    // Session sequence of the decryption path
    // S_DONE and S_FAIL are terminal until the next reset
    typedef enum logic [2:0] {
        S_WAIT_KEY,
        S_WAIT_PASS,
        S_PROCESS,
        S_TRAILER,
        S_DONE,
        S_FAIL
    } session_state_t;

    // Number of status LEDs on the board
    localparam int LED_W = 7;

    // Bit positions of the individual LEDs in the status vector
    localparam int LED_PASS_OK  = 0;
    localparam int LED_PASS_BAD = 1;
    localparam int LED_ON       = 2;
    localparam int LED_READY    = 3;
    localparam int LED_PROC     = 4;
    localparam int LED_SUCCESS  = 5;
    localparam int LED_FAILURE  = 6;

    // Result of one passphrase attempt, each field is a one-cycle pulse
    // Exhausted only comes together with reject on the final allowed try
    typedef struct packed {
        logic accept;
        logic reject;
        logic exhausted;
    } pass_verdict_t;

endpackage

`default_nettype wire

// ==== verilog/passphrase_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module passphrase_checker #(
    parameter int PASS_LEN  = 4,
    parameter int MAX_TRIES = 3
) (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             en_i,
    input  logic [mfe_stream_pkg::CHAR_W-1:0] char_i,
    input  logic                             char_valid_i,
    input  logic [15:0]                      check_i,
    output mfe_ctrl_pkg::pass_verdict_t      verdict_o
);

    // Counter widths sized so the full range fits
    localparam int CW = $clog2(PASS_LEN + 1);
    localparam int TW = $clog2(MAX_TRIES + 1);

    // Position of the final character of an attempt
    localparam logic [CW-1:0] LAST_CHAR = CW'(PASS_LEN - 1);
    // Attempt count seen just before the final allowed reject
    localparam logic [TW-1:0] LAST_TRY = TW'(MAX_TRIES - 1);

    logic [15:0]   sum_q;
    logic [15:0]   sum_next;
    logic [CW-1:0] char_cnt_q;
    logic [TW-1:0] tries_q;
    logic          char_take;
    logic          last_char;

    // Only characters arriving while the FSM waits for a passphrase count
    assign char_take = en_i && char_valid_i;
    assign last_char = (char_cnt_q == LAST_CHAR);

    // Rotate left by one and fold in the zero-extended character
    assign sum_next = {sum_q[14:0], sum_q[15]} ^ 16'(char_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sum_q      <= '0;
            char_cnt_q <= '0;
            tries_q    <= '0;
            verdict_o  <= '0;
        end else begin
            // Verdict fields are pulses and drop back every cycle
            verdict_o <= '0;
            if (char_take) begin
                if (last_char) begin
                    // The attempt ends here, so the fold restarts from zero
                    sum_q      <= '0;
                    char_cnt_q <= '0;
                    if (sum_next == check_i) begin
                        verdict_o.accept <= 1'b1;
                    end else begin
                        verdict_o.reject <= 1'b1;
                        tries_q          <= tries_q + 1'b1;
                        // The MAX_TRIES-th miss ends the session
                        if (tries_q == LAST_TRY) begin
                            verdict_o.exhausted <= 1'b1;
                        end
                    end
                end else begin
                    sum_q      <= sum_next;
                    char_cnt_q <= char_cnt_q + 1'b1;
                end
            end
        end
    end

    // A single attempt resolves to exactly one outcome
    a_one_outcome: assert property (
        @(posedge clk) disable iff (rst_i)
        !(verdict_o.accept && verdict_o.reject)
    );

endmodule

`default_nettype wire

// ==== verilog/word_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_counter #(
    parameter int CNT_W = 16
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             clear_i,
    input  logic             word_taken_i,
    output logic [CNT_W-1:0] count_o
);

    // Largest value the counter can show before it sticks
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    logic at_max;

    assign at_max = (count_o == CNT_MAX);

    // Counts every accepted data word of the file including the eof word
    // A very long file saturates instead of rolling over to a small count
    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_o <= '0;
        end else if (clear_i) begin
            count_o <= '0;
        end else if (word_taken_i && !at_max) begin
            count_o <= count_o + 1'b1;
        end
    end

    // Once nonzero the count can only return to zero through a clear
    a_no_wrap: assert property (
        @(posedge clk) disable iff (rst_i)
        (count_o != '0 && !clear_i) |=> (count_o != '0)
    );

endmodule

`default_nettype wire

// ==== verilog/keystream_decryptor.sv ====
`timescale 1ns/1ps
`default_nettype none

module keystream_decryptor #(
    parameter int CNT_W = 16
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic [15:0]                  seed_i,
    input  logic                         proc_en_i,
    input  logic                         trailer_req_i,
    input  logic [CNT_W-1:0]             count_i,
    input  mfe_stream_pkg::stream_word_t dat_i,
    input  logic                         dat_valid_i,
    input  logic                         out_ready_i,
    output logic                         dat_ready_o,
    output mfe_stream_pkg::stream_word_t out_o,
    output logic                         out_valid_o,
    output logic                         word_taken_o,
    output logic                         eof_taken_o,
    output logic                         trailer_done_o
);
    import mfe_stream_pkg::*;

    // One Galois step, shift right and fold in the taps on a 1 shifted out
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] shifted;
        shifted = {1'b0, s[31:1]};
        if (s[0]) begin
            shifted = shifted ^ LFSR_TAPS;
        end
        return shifted;
    endfunction

    logic [31:0] lfsr_q;
    logic [31:0] seed_init;
    logic [31:0] ks_cur;
    logic        proc_en_q;
    logic        proc_start;
    logic        slot_free;
    logic        trailer_loaded_q;
    logic        trailer_load;

    // A zero seed would lock the LFSR, so it starts from all ones instead
    assign seed_init = (seed_i == '0) ? '1 : {seed_i, seed_i};

    // First cycle of processing, the register still holds an old state
    assign proc_start = proc_en_i && !proc_en_q;
    // The very first word may arrive in that cycle, so bypass the load
    assign ks_cur = proc_start ? seed_init : lfsr_q;

    // The output register can take a word if it is empty or draining now
    assign slot_free    = !out_valid_o || out_ready_i;
    assign dat_ready_o  = proc_en_i && slot_free;
    assign word_taken_o = dat_valid_i && dat_ready_o;
    assign eof_taken_o  = word_taken_o && dat_i.eof;

    // The trailer goes into the same register once, after the eof word
    assign trailer_load = trailer_req_i && !trailer_loaded_q && slot_free;

    // Only the trailer leaves with eof set
    assign trailer_done_o = out_valid_o && out_ready_i && out_o.eof;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o      <= 1'b0;
            proc_en_q        <= 1'b0;
            trailer_loaded_q <= 1'b0;
        end else begin
            proc_en_q <= proc_en_i;
            if (word_taken_o || trailer_load) begin
                out_valid_o <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_o <= 1'b0;
            end
            if (proc_start) begin
                trailer_loaded_q <= 1'b0;
            end else if (trailer_load) begin
                trailer_loaded_q <= 1'b1;
            end
        end
    end

    // Output word and keystream state carry data only
    always_ff @(posedge clk) begin
        if (word_taken_o) begin
            out_o.data <= dat_i.data ^ ks_cur;
            out_o.eof  <= 1'b0;
        end else if (trailer_load) begin
            out_o.data <= 32'(count_i);
            out_o.eof  <= 1'b1;
        end
        // The keystream advances once per accepted word
        if (word_taken_o) begin
            lfsr_q <= lfsr_step(ks_cur);
        end else if (proc_start) begin
            lfsr_q <= seed_init;
        end
    end

    // A stalled output word is held unchanged until the consumer takes it
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_o))
    );

endmodule

`default_nettype wire

// ==== verilog/session_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module session_fsm (
    input  logic                              clk,
    input  logic                              rst_i,
    input  mfe_stream_pkg::key_word_u         key_i,
    input  logic                              key_valid_i,
    input  mfe_ctrl_pkg::pass_verdict_t       verdict_i,
    input  logic                              eof_taken_i,
    input  logic                              trailer_done_i,
    output mfe_stream_pkg::key_word_u         key_o,
    output logic                              pass_en_o,
    output logic                              proc_en_o,
    output logic                              trailer_req_o,
    output logic                              clear_o,
    output logic [mfe_ctrl_pkg::LED_W-1:0]    status_leds_o
);
    import mfe_ctrl_pkg::*;

    session_state_t state_q;
    session_state_t state_d;
    logic           key_load;
    logic           pass_bad_q;

    // The key card word is only taken once, while the session waits for it
    assign key_load = (state_q == S_WAIT_KEY) && key_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_WAIT_KEY: begin
                if (key_valid_i) begin
                    state_d = S_WAIT_PASS;
                end
            end
            S_WAIT_PASS: begin
                // A match wins, otherwise the final miss ends the session
                if (verdict_i.accept) begin
                    state_d = S_PROCESS;
                end else if (verdict_i.exhausted) begin
                    state_d = S_FAIL;
                end
            end
            S_PROCESS: begin
                if (eof_taken_i) begin
                    state_d = S_TRAILER;
                end
            end
            S_TRAILER: begin
                if (trailer_done_i) begin
                    state_d = S_DONE;
                end
            end
            // Done and fail wait for a reset
            default: begin
                state_d = state_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= S_WAIT_KEY;
            pass_bad_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // The bad-passphrase light stays on until a good attempt
            if (state_q == S_WAIT_PASS) begin
                if (verdict_i.reject) begin
                    pass_bad_q <= 1'b1;
                end else if (verdict_i.accept) begin
                    pass_bad_q <= 1'b0;
                end
            end
        end
    end

    // Key register feeds the check value and the seed to the datapath
    always_ff @(posedge clk) begin
        if (key_load) begin
            key_o <= key_i;
        end
    end

    // Per-state enables for the datapath blocks
    assign pass_en_o     = (state_q == S_WAIT_PASS);
    assign proc_en_o     = (state_q == S_PROCESS);
    assign trailer_req_o = (state_q == S_TRAILER);
    // The word count restarts while the passphrase is being entered
    assign clear_o       = (state_q == S_WAIT_PASS);

    // Status LEDs are decoded from state and the reject flag
    always_comb begin
        status_leds_o               = '0;
        status_leds_o[LED_ON]       = 1'b1;
        status_leds_o[LED_READY]    = (state_q != S_WAIT_KEY);
        status_leds_o[LED_PASS_OK]  = state_q inside {S_PROCESS, S_TRAILER, S_DONE};
        status_leds_o[LED_PASS_BAD] = pass_bad_q;
        status_leds_o[LED_PROC]     = state_q inside {S_PROCESS, S_TRAILER};
        status_leds_o[LED_SUCCESS]  = (state_q == S_DONE);
        status_leds_o[LED_FAILURE]  = (state_q == S_FAIL);
    end

    // The decryptor only finishes a trailer that this FSM asked for
    a_trailer_in_state: assert property (
        @(posedge clk) disable iff (rst_i)
        trailer_done_i |-> (state_q == S_TRAILER)
    );

endmodule

`default_nettype wire

// ==== verilog/mfe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mfe_top #(
    parameter int PASS_LEN  = 4,
    parameter int MAX_TRIES = 3,
    parameter int CNT_W     = 16
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  mfe_stream_pkg::key_word_u         key_i,
    input  logic                              key_valid_i,
    input  logic [mfe_stream_pkg::CHAR_W-1:0] char_i,
    input  logic                              char_valid_i,
    input  mfe_stream_pkg::stream_word_t      dat_i,
    input  logic                              dat_valid_i,
    input  logic                              out_ready_i,
    output logic                              dat_ready_o,
    output mfe_stream_pkg::stream_word_t      out_o,
    output logic                              out_valid_o,
    output logic [mfe_ctrl_pkg::LED_W-1:0]    status_leds_o
);
    import mfe_stream_pkg::*;
    import mfe_ctrl_pkg::*;

    // Key register contents, read as check value and seed
    key_word_u        key;
    pass_verdict_t    verdict;
    // FSM enables to the datapath
    logic             pass_en, proc_en, trailer_req, clear;
    // Datapath events back to the FSM and the counter
    logic             word_taken, eof_taken, trailer_done;
    logic [CNT_W-1:0] count;

    session_fsm u_fsm (
        .clk(clk), .rst_i(rst_i),
        .key_i(key_i), .key_valid_i(key_valid_i),
        .verdict_i(verdict),
        .eof_taken_i(eof_taken), .trailer_done_i(trailer_done),
        .key_o(key), .pass_en_o(pass_en), .proc_en_o(proc_en),
        .trailer_req_o(trailer_req), .clear_o(clear),
        .status_leds_o(status_leds_o)
    );

    passphrase_checker #(.PASS_LEN(PASS_LEN), .MAX_TRIES(MAX_TRIES)) u_checker (
        .clk(clk), .rst_i(rst_i), .en_i(pass_en),
        .char_i(char_i), .char_valid_i(char_valid_i),
        .check_i(key.f.check), .verdict_o(verdict)
    );

    word_counter #(.CNT_W(CNT_W)) u_counter (
        .clk(clk), .rst_i(rst_i), .clear_i(clear),
        .word_taken_i(word_taken), .count_o(count)
    );

    keystream_decryptor #(.CNT_W(CNT_W)) u_decrypt (
        .clk(clk), .rst_i(rst_i), .seed_i(key.f.seed),
        .proc_en_i(proc_en), .trailer_req_i(trailer_req), .count_i(count),
        .dat_i(dat_i), .dat_valid_i(dat_valid_i), .out_ready_i(out_ready_i),
        .dat_ready_o(dat_ready_o), .out_o(out_o), .out_valid_o(out_valid_o),
        .word_taken_o(word_taken), .eof_taken_o(eof_taken),
        .trailer_done_o(trailer_done)
    );

endmodule

`default_nettype wire

// ==== bench/tb_mfe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mfe;
    import mfe_stream_pkg::*;
    import mfe_ctrl_pkg::*;

    localparam int PASS_LEN  = 4;
    localparam int MAX_TRIES = 3;
    localparam int CNT_W     = 16;
    localparam int PW        = PASS_LEN * CHAR_W;

    logic               clk;
    logic               rst_i;
    key_word_u          key_i;
    logic               key_valid_i;
    logic [CHAR_W-1:0]  char_i;
    logic               char_valid_i;
    stream_word_t       dat_i;
    logic               dat_valid_i;
    logic               out_ready_i;
    logic               dat_ready_o;
    stream_word_t       out_o;
    logic               out_valid_o;
    logic [LED_W-1:0]   status_leds_o;

    // Expected output words in transfer order are filled before each file is sent
    stream_word_t       exp_q[$];
    stream_word_t       held_q;
    stream_word_t       exp_w;
    bit                 took_q;
    bit                 stall_q;
    bit                 stall_mode;
    int                 err_cnt;
    int                 err_mark;
    int                 fail_tests;
    int                 cycles;
    int                 limit = 1000000;

    mfe_top #(.PASS_LEN(PASS_LEN), .MAX_TRIES(MAX_TRIES), .CNT_W(CNT_W)) UUT (
        .clk(clk), .rst_i(rst_i), .key_i(key_i), .key_valid_i(key_valid_i),
        .char_i(char_i), .char_valid_i(char_valid_i),
        .dat_i(dat_i), .dat_valid_i(dat_valid_i), .out_ready_i(out_ready_i),
        .dat_ready_o(dat_ready_o), .out_o(out_o), .out_valid_o(out_valid_o),
        .status_leds_o(status_leds_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Checksum of a passphrase in which character 0 is typed first
    function automatic logic [15:0] ref_checksum(input logic [PW-1:0] p);
        logic [15:0] s;
        int          i;
        s = '0;
        for (i = 0; i < PASS_LEN; i++) begin
            s = {s[14:0], s[15]} ^ 16'(p[i*CHAR_W +: CHAR_W]);
        end
        return s;
    endfunction

    // Keystream state at the start of a file where a zero seed means all ones
    function automatic logic [31:0] ks_start(input logic [15:0] seed);
        return (seed == 16'h0) ? 32'hffff_ffff : {seed, seed};
    endfunction

    function automatic logic [31:0] ks_advance(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] ref_decrypt(input logic [31:0] d, input logic [31:0] ks);
        return d ^ ks;
    endfunction

    function automatic logic [PW-1:0] make_passphrase();
        logic [PW-1:0] p;
        int            i;
        for (i = 0; i < PASS_LEN; i++) begin
            p[i*CHAR_W +: CHAR_W] = CHAR_W'($urandom);
        end
        return p;
    endfunction

    // Random passphrase that is guaranteed to miss the check value
    function automatic logic [PW-1:0] make_wrong(input logic [15:0] check);
        logic [PW-1:0] p;
        p = make_passphrase();
        if (ref_checksum(p) == check) begin
            p[0] = ~p[0];
        end
        return p;
    endfunction

    function automatic logic [LED_W-1:0] expect_leds(input bit ready, input bit ok,
            input bit bad, input bit proc, input bit done, input bit fail);
        logic [LED_W-1:0] v;
        v = '0;
        v[LED_ON]       = 1'b1;
        v[LED_READY]    = ready;
        v[LED_PASS_OK]  = ok;
        v[LED_PASS_BAD] = bad;
        v[LED_PROC]     = proc;
        v[LED_SUCCESS]  = done;
        v[LED_FAILURE]  = fail;
        return v;
    endfunction

    task automatic check_leds(input logic [LED_W-1:0] exp);
        if (status_leds_o !== exp) begin
            $display("ERR t=%0t status_leds_o got %b exp %b", $time, status_leds_o, exp);
            err_cnt++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_i        = 1'b1;
        key_valid_i  = 1'b0;
        char_valid_i = 1'b0;
        dat_valid_i  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
    endtask

    // The key is taken at the edge inside the strobe, so LEDs are valid on return
    task automatic strobe_key(input logic [31:0] raw);
        @(negedge clk);
        key_i.raw   = raw;
        key_valid_i = 1'b1;
        @(negedge clk);
        key_valid_i = 1'b0;
    endtask

    // Returns two edges after the last character when the verdict has reached the LEDs
    task automatic type_passphrase(input logic [PW-1:0] p);
        int i;
        for (i = 0; i < PASS_LEN; i++) begin
            @(negedge clk);
            char_i       = p[i*CHAR_W +: CHAR_W];
            char_valid_i = 1'b1;
        end
        @(negedge clk);
        char_valid_i = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic run_file(input int len, input logic [15:0] seed, input bit stall);
        logic [31:0]  words[$];
        logic [31:0]  ks;
        stream_word_t sw;
        int           i;
        ks = ks_start(seed);
        for (i = 0; i < len; i++) begin
            words.push_back($urandom);
            sw.data = ref_decrypt(words[i], ks);
            sw.eof  = 1'b0;
            exp_q.push_back(sw);
            ks = ks_advance(ks);
        end
        // Trailer counts every data word of the file and carries the eof flag
        sw.data = 32'(len);
        sw.eof  = 1'b1;
        exp_q.push_back(sw);
        stall_mode = stall;
        for (i = 0; i < len; i++) begin
            @(negedge clk);
            dat_valid_i = 1'b1;
            dat_i.data  = words[i];
            dat_i.eof   = (i == len - 1);
            @(posedge clk);
            while (!dat_ready_o) begin
                @(posedge clk);
            end
        end
        @(negedge clk);
        dat_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        stall_mode = 1'b0;
    endtask

    task automatic finish_test(input int num, input string name);
        if (err_cnt == err_mark) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            fail_tests++;
            $display("Test %0d %s: %0d errors", num, name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    // The consumer stalls at random only while a stalled file is running
    initial begin
        out_ready_i = 1'b1;
        forever begin
            @(negedge clk);
            out_ready_i = stall_mode ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    // The comparator samples at the rising edge before any register updates
    always @(posedge clk) begin
        if (rst_i) begin
            took_q  = 1'b0;
            stall_q = 1'b0;
        end else begin
            if (took_q && !out_valid_o) begin
                $display("Word accepted at the previous edge is missing on out_o at t=%0t",
                         $time);
                err_cnt++;
            end
            if (stall_q && out_o !== held_q) begin
                $display("ERR t=%0t out_o got %h exp %h", $time, out_o, held_q);
                err_cnt++;
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("Output word %h arrived with none expected at t=%0t", out_o, $time);
                    err_cnt++;
                end else begin
                    exp_w = exp_q.pop_front();
                    if (out_o !== exp_w) begin
                        $display("ERR t=%0t out_o got %h exp %h", $time, out_o, exp_w);
                        err_cnt++;
                    end
                end
            end
            took_q  = dat_valid_i && dat_ready_o;
            stall_q = out_valid_o && !out_ready_i;
            held_q  = out_o;
        end
    end

    // Watchdog sized from the stimulus length
    initial begin
        cycles = 0;
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [PW-1:0] pass;
        logic [15:0]   check;
        logic [15:0]   seed;
        int unsigned   len_a;
        int unsigned   len_b;
        int unsigned   len_c;
        int            i;
        void'($urandom(32'hcff3));
        rst_i        = 1'b1;
        key_i        = '0;
        key_valid_i  = 1'b0;
        char_i       = '0;
        char_valid_i = 1'b0;
        dat_i        = '0;
        dat_valid_i  = 1'b0;
        stall_mode   = 1'b0;
        len_a        = 4 + ($urandom % 16);
        len_b        = 4 + ($urandom % 16);
        len_c        = 4 + ($urandom % 16);
        // The limit covers seven passphrase attempts and one trailer per file
        limit        = 20 * (len_a + len_b + len_c + 3 + 7 * PASS_LEN) + 500;
        pass         = make_passphrase();
        check        = ref_checksum(pass);
        seed         = 16'($urandom);
        if (seed == 16'h0) begin
            seed = 16'h1;
        end

        apply_reset();
        check_leds(expect_leds(0, 0, 0, 0, 0, 0));
        if (dat_ready_o !== 1'b0 || out_valid_o !== 1'b0) begin
            $display("ERR t=%0t dat_ready_o/out_valid_o got %b%b exp 00", $time,
                     dat_ready_o, out_valid_o);
            err_cnt++;
        end
        strobe_key({check, seed});
        check_leds(expect_leds(1, 0, 0, 0, 0, 0));
        finish_test(1, "reset and key load");

        type_passphrase(make_wrong(check));
        check_leds(expect_leds(1, 0, 1, 0, 0, 0));
        type_passphrase(pass);
        check_leds(expect_leds(1, 1, 0, 1, 0, 0));
        finish_test(2, "wrong then correct passphrase");

        run_file(len_a, seed, 1'b0);
        check_leds(expect_leds(1, 1, 0, 0, 1, 0));
        finish_test(3, "file without stalls");

        apply_reset();
        strobe_key({check, seed});
        type_passphrase(pass);
        run_file(len_b, seed, 1'b1);
        check_leds(expect_leds(1, 1, 0, 0, 1, 0));
        finish_test(4, "file with output stalls");

        apply_reset();
        strobe_key({check, seed});
        repeat (MAX_TRIES) type_passphrase(make_wrong(check));
        check_leds(expect_leds(1, 0, 1, 0, 0, 1));
        // The locked session must never take the data offered here
        @(negedge clk);
        dat_valid_i = 1'b1;
        for (i = 0; i < 20; i++) begin
            @(posedge clk);
            if (dat_ready_o !== 1'b0) begin
                $display("ERR t=%0t dat_ready_o got %b exp 0", $time, dat_ready_o);
                err_cnt++;
            end
        end
        @(negedge clk);
        dat_valid_i = 1'b0;
        finish_test(5, "passphrase attempts exhausted");

        apply_reset();
        strobe_key({check, 16'h0});
        type_passphrase(pass);
        run_file(len_c, 16'h0, 1'b0);
        check_leds(expect_leds(1, 1, 0, 0, 1, 0));
        finish_test(6, "zero seed");

        $display("Tests run: 6, failed: %0d, errors: %0d", fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/mfe_stream_pkg.sv
verilog/mfe_ctrl_pkg.sv
verilog/passphrase_checker.sv
verilog/word_counter.sv
verilog/keystream_decryptor.sv
verilog/session_fsm.sv
verilog/mfe_top.sv
bench/tb_mfe.sv
